// ==== hammerparrot_pkg.sv ====
package hammerparrot_pkg;

  // Word address, data and trace ROM widths
  localparam int HP_ADDR_W    = 12;
  localparam int HP_DATA_W    = 32;
  localparam int HP_TRACE_W   = 20;
  localparam int HP_CMD_W     = 4;
  localparam int HP_PAYLOAD_W = HP_TRACE_W - HP_CMD_W;

  // Control space register select values
  localparam logic [1:0] HP_REG_WR_COUNT = 2'd0;

  // Trace commands sit in the top nibble of each ROM word
  typedef enum logic [HP_CMD_W-1:0] {
    CMD_SET_BASE  = 4'h1,
    CMD_SET_COUNT = 4'h2,
    CMD_SET_SEED  = 4'h3,
    CMD_END       = 4'hf
  } hp_trace_cmd_e;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } hp_op_e;

  // The top address bit picks between the memory array and the control registers
  typedef struct packed {
    logic                 space;
    logic [HP_ADDR_W-2:0] index;
  } hp_mem_view_s;

  typedef struct packed {
    logic                 space;
    logic [HP_ADDR_W-4:0] unused;
    logic [1:0]           reg_sel;
  } hp_ctrl_view_s;

  typedef union packed {
    hp_mem_view_s  mem;
    hp_ctrl_view_s ctrl;
  } hp_addr_u;

endpackage

// ==== hp_link_if.sv ====
`timescale 1ns/10ps

interface hp_link_if ();

  // Request channel
  logic                                   req_valid;
  logic                                   req_ready;
  hammerparrot_pkg::hp_op_e               req_op;
  hammerparrot_pkg::hp_addr_u             req_addr;
  logic [hammerparrot_pkg::HP_DATA_W-1:0] req_wdata;

  // Response channel, no back-pressure
  logic                                   rsp_valid;
  logic [hammerparrot_pkg::HP_DATA_W-1:0] rsp_rdata;

  modport requester (
    output req_valid, req_op, req_addr, req_wdata,
    input  req_ready, rsp_valid, rsp_rdata
  );

  modport responder (
    input  req_valid, req_op, req_addr, req_wdata,
    output req_ready, rsp_valid, rsp_rdata
  );

endinterface

// ==== tag_trace_replay.sv ====
`timescale 1ns/10ps

module tag_trace_replay #(
  parameter int ROM_WORDS = 16
) (
  input  logic                                   hammerparrot_clk,
  input  logic                                   rst_n_i,
  output logic [$clog2(ROM_WORDS)-1:0]           rom_addr_o,
  input  logic [hammerparrot_pkg::HP_TRACE_W-1:0] rom_data_i,
  output logic [hammerparrot_pkg::HP_ADDR_W-1:0]  load_base_o,
  output logic [11:0]                            load_count_o,
  output logic [hammerparrot_pkg::HP_DATA_W-1:0]  load_seed_o,
  output logic                                   config_done_o
);

  localparam int ROM_AW  = $clog2(ROM_WORDS);
  localparam int ADDR_W  = hammerparrot_pkg::HP_ADDR_W;
  localparam int DATA_W  = hammerparrot_pkg::HP_DATA_W;
  localparam int TRACE_W = hammerparrot_pkg::HP_TRACE_W;
  localparam int CMD_W   = hammerparrot_pkg::HP_CMD_W;
  localparam int PAY_W   = hammerparrot_pkg::HP_PAYLOAD_W;

  hammerparrot_pkg::hp_trace_cmd_e cmd;
  logic [PAY_W-1:0]                payload;
  logic [ROM_AW-1:0]               addr_q;
  logic                            done_q;
  logic                            last_word;

  assign cmd       = hammerparrot_pkg::hp_trace_cmd_e'(rom_data_i[TRACE_W-1 -: CMD_W]);
  assign payload   = rom_data_i[PAY_W-1:0];
  // A trace without an end marker still finishes on the last ROM word
  assign last_word = (addr_q == ROM_AW'(ROM_WORDS - 1));

  always_ff @(posedge hammerparrot_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      addr_q       <= '0;
      done_q       <= 1'b0;
      load_base_o  <= '0;
      load_count_o <= '0;
      load_seed_o  <= '0;
    end
    else if (!done_q)
    begin
      case (cmd)
        hammerparrot_pkg::CMD_SET_BASE:  load_base_o  <= payload[ADDR_W-1:0];
        hammerparrot_pkg::CMD_SET_COUNT: load_count_o <= payload[11:0];
        hammerparrot_pkg::CMD_SET_SEED:  load_seed_o  <= DATA_W'(payload);
        default: ;
      endcase
      if (cmd == hammerparrot_pkg::CMD_END || last_word)
        done_q <= 1'b1;
      else
        addr_q <= addr_q + 1'b1;
    end
  end

  assign rom_addr_o    = addr_q;
  assign config_done_o = done_q;

endmodule

// ==== axil_host_bridge.sv ====
`timescale 1ns/10ps

module axil_host_bridge (
  input  logic        hammerparrot_clk,
  input  logic        rst_n_i,
  input  logic        enable_i,
  input  logic [15:0] awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] wdata_i,
  // Byte strobes are ignored, every write covers the full word
  input  logic [3:0]  wstrb_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o,
  input  logic        bready_i,
  input  logic [15:0] araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [31:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  logic        rready_i,
  hp_link_if.requester link
);

  localparam int ADDR_W = hammerparrot_pkg::HP_ADDR_W;
  localparam int DATA_W = hammerparrot_pkg::HP_DATA_W;
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_REQ   = 3'd1;
  localparam logic [2:0] ST_WAIT  = 3'd2;
  localparam logic [2:0] ST_BRESP = 3'd3;
  localparam logic [2:0] ST_RRESP = 3'd4;

  logic [2:0]               state_q;
  hammerparrot_pkg::hp_op_e op_q;
  logic [ADDR_W-1:0]        addr_q;
  logic [DATA_W-1:0]        wdata_q;
  logic [DATA_W-1:0]        rdata_q;
  logic                     idle;
  logic                     wr_accept;
  logic                     rd_accept;

  // Nothing is accepted before configuration ends, and writes win over reads
  assign idle      = enable_i && (state_q == ST_IDLE);
  assign wr_accept = idle && awvalid_i && wvalid_i;
  assign rd_accept = idle && arvalid_i && !(awvalid_i && wvalid_i);

  always_ff @(posedge hammerparrot_clk)
  begin
    if (wr_accept)
    begin
      op_q    <= hammerparrot_pkg::OP_WRITE;
      addr_q  <= awaddr_i[ADDR_W+1:2];
      wdata_q <= wdata_i;
    end
    else if (rd_accept)
    begin
      op_q   <= hammerparrot_pkg::OP_READ;
      addr_q <= araddr_i[ADDR_W+1:2];
    end
    if (state_q == ST_WAIT && link.rsp_valid)
      rdata_q <= link.rsp_rdata;
  end

  always_ff @(posedge hammerparrot_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      state_q <= ST_IDLE;
    else
      case (state_q)
        ST_IDLE:  if (wr_accept || rd_accept) state_q <= ST_REQ;
        ST_REQ:   if (link.req_ready) state_q <= ST_WAIT;
        ST_WAIT:
          if (link.rsp_valid)
            state_q <= (op_q == hammerparrot_pkg::OP_WRITE) ? ST_BRESP : ST_RRESP;
        ST_BRESP: if (bready_i) state_q <= ST_IDLE;
        ST_RRESP: if (rready_i) state_q <= ST_IDLE;
        default:  state_q <= ST_IDLE;
      endcase
  end

  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;
  assign arready_o = rd_accept;
  assign bvalid_o  = (state_q == ST_BRESP);
  assign bresp_o   = RESP_OKAY;
  assign rvalid_o  = (state_q == ST_RRESP);
  assign rresp_o   = RESP_OKAY;
  assign rdata_o   = rdata_q;

  assign link.req_valid = (state_q == ST_REQ);
  assign link.req_op    = op_q;
  assign link.req_addr  = addr_q;
  assign link.req_wdata = wdata_q;

endmodule

// ==== io_loader.sv ====
`timescale 1ns/10ps

module io_loader (
  input  logic                                   hammerparrot_clk,
  input  logic                                   rst_n_i,
  input  logic                                   start_i,
  input  logic [hammerparrot_pkg::HP_ADDR_W-1:0]  load_base_i,
  input  logic [11:0]                            load_count_i,
  input  logic [hammerparrot_pkg::HP_DATA_W-1:0]  load_seed_i,
  hp_link_if.requester                           link,
  output logic                                   loader_done_o
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_REQ  = 2'd1;
  localparam logic [1:0] ST_WAIT = 2'd2;
  localparam logic [1:0] ST_DONE = 2'd3;

  logic [1:0]                             state_q;
  logic [11:0]                            left_q;
  logic [hammerparrot_pkg::HP_ADDR_W-1:0] addr_q;
  logic [hammerparrot_pkg::HP_DATA_W-1:0] data_q;

  // Address and pattern advance together, one step per write response
  always_ff @(posedge hammerparrot_clk)
  begin
    if (state_q == ST_IDLE)
    begin
      addr_q <= load_base_i;
      data_q <= load_seed_i;
    end
    else if (state_q == ST_WAIT && link.rsp_valid)
    begin
      addr_q <= addr_q + 1'b1;
      data_q <= data_q + 1'b1;
    end
  end

  always_ff @(posedge hammerparrot_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= ST_IDLE;
      left_q  <= '0;
    end
    else
      case (state_q)
        ST_IDLE:
          if (start_i)
          begin
            left_q  <= load_count_i;
            state_q <= (load_count_i == '0) ? ST_DONE : ST_REQ;
          end
        ST_REQ: if (link.req_ready) state_q <= ST_WAIT;
        ST_WAIT:
          if (link.rsp_valid)
          begin
            left_q  <= left_q - 1'b1;
            state_q <= (left_q == 12'd1) ? ST_DONE : ST_REQ;
          end
        default: ;  // Done holds until reset
      endcase
  end

  assign link.req_valid = (state_q == ST_REQ);
  assign link.req_op    = hammerparrot_pkg::OP_WRITE;
  assign link.req_addr  = addr_q;
  assign link.req_wdata = data_q;
  assign loader_done_o  = (state_q == ST_DONE);

endmodule

// ==== link_arbiter.sv ====
`timescale 1ns/10ps

module link_arbiter (
  input  logic         hammerparrot_clk,
  input  logic         rst_n_i,
  hp_link_if.responder host,
  hp_link_if.responder load,
  hp_link_if.requester mem
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_FWD  = 2'd1;
  localparam logic [1:0] ST_WAIT = 2'd2;

  logic [1:0] state_q;
  logic       owner_q;         // Set when the loader holds the grant
  logic       favour_load_q;
  logic       pick_load;
  logic       fwd;
  logic       rsp_done;

  // On a tie the favoured side wins, otherwise whoever is asking
  assign pick_load = load.req_valid && (!host.req_valid || favour_load_q);
  assign fwd       = (state_q == ST_FWD);
  assign rsp_done  = (state_q == ST_WAIT) && mem.rsp_valid;

  always_ff @(posedge hammerparrot_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q       <= ST_IDLE;
      owner_q       <= 1'b0;
      favour_load_q <= 1'b0;
    end
    else
      case (state_q)
        ST_IDLE:
          if (host.req_valid || load.req_valid)
          begin
            owner_q <= pick_load;
            state_q <= ST_FWD;
          end
        ST_FWD: if (mem.req_valid && mem.req_ready) state_q <= ST_WAIT;
        ST_WAIT:
          if (mem.rsp_valid)
          begin
            state_q       <= ST_IDLE;
            favour_load_q <= !owner_q;
          end
        default: state_q <= ST_IDLE;
      endcase
  end

  //////////////////////////////////////////////////
  // Request steering from the owner to memory

  assign mem.req_valid = fwd && (owner_q ? load.req_valid : host.req_valid);
  assign mem.req_op    = owner_q ? load.req_op    : host.req_op;
  assign mem.req_addr  = owner_q ? load.req_addr  : host.req_addr;
  assign mem.req_wdata = owner_q ? load.req_wdata : host.req_wdata;

  assign host.req_ready = fwd && !owner_q && mem.req_ready;
  assign load.req_ready = fwd && owner_q && mem.req_ready;

  //////////////////////////////////////////////////
  // Response goes back only to the owner

  assign host.rsp_valid = rsp_done && !owner_q;
  assign load.rsp_valid = rsp_done && owner_q;
  assign host.rsp_rdata = mem.rsp_rdata;
  assign load.rsp_rdata = mem.rsp_rdata;

endmodule

// ==== mem_endpoint.sv ====
`timescale 1ns/10ps

module mem_endpoint #(
  parameter int MEM_WORDS = 256
) (
  input  logic         hammerparrot_clk,
  input  logic         rst_n_i,
  hp_link_if.responder link
);

  localparam int IDX_W  = $clog2(MEM_WORDS);
  localparam int DATA_W = hammerparrot_pkg::HP_DATA_W;

  logic [DATA_W-1:0] mem_q [MEM_WORDS];
  logic [DATA_W-1:0] wr_count_q;
  logic [DATA_W-1:0] rdata_q;
  logic              ready_q;
  logic              rsp_valid_q;
  logic              xfer;
  logic              ctrl_space;
  logic              is_write;
  logic [IDX_W-1:0]  idx;

  assign xfer       = link.req_valid && ready_q;
  assign ctrl_space = link.req_addr.mem.space;
  assign is_write   = (link.req_op == hammerparrot_pkg::OP_WRITE);
  // Indices beyond the array depth wrap around
  assign idx        = link.req_addr.mem.index[IDX_W-1:0];

  always_ff @(posedge hammerparrot_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ready_q     <= 1'b0;
      rsp_valid_q <= 1'b0;
      wr_count_q  <= '0;
    end
    else
    begin
      ready_q     <= 1'b1;
      rsp_valid_q <= xfer;
      if (xfer && is_write && !ctrl_space)
        wr_count_q <= wr_count_q + 1'b1;
    end
  end

  // Control space writes have no effect
  always_ff @(posedge hammerparrot_clk)
  begin
    if (xfer && !ctrl_space)
    begin
      if (is_write)
        mem_q[idx] <= link.req_wdata;
      rdata_q <= mem_q[idx];
    end
    else if (xfer)
      rdata_q <= (link.req_addr.ctrl.reg_sel == hammerparrot_pkg::HP_REG_WR_COUNT) ?
                 wr_count_q : '0;
  end

  assign link.req_ready = ready_q;
  assign link.rsp_valid = rsp_valid_q;
  assign link.rsp_rdata = rdata_q;

endmodule

// ==== hammerparrot_top.sv ====
`timescale 1ns/10ps

module hammerparrot_top #(
  parameter int MEM_WORDS = 256,
  parameter int ROM_WORDS = 16
) (
  input  logic        hammerparrot_clk,
  input  logic        rst_n_i,
  input  logic [15:0] awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o,
  input  logic        bready_i,
  input  logic [15:0] araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [31:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  logic        rready_i,
  output logic        config_done_o,
  output logic        loader_done_o
);

  logic [hammerparrot_pkg::HP_TRACE_W-1:0] rom_q [ROM_WORDS];
  logic [$clog2(ROM_WORDS)-1:0]            rom_addr;
  logic [hammerparrot_pkg::HP_TRACE_W-1:0] rom_data;
  logic [hammerparrot_pkg::HP_ADDR_W-1:0]  load_base;
  logic [11:0]                             load_count;
  logic [hammerparrot_pkg::HP_DATA_W-1:0]  load_seed;
  logic                                    config_done;

  // Configuration trace ROM
  initial $readmemh("trace.mem", rom_q);
  assign rom_data = rom_q[rom_addr];

  hp_link_if link_host ();
  hp_link_if link_load ();
  hp_link_if link_mem ();

  tag_trace_replay #(.ROM_WORDS(ROM_WORDS)) u_tag_trace_replay (
    .hammerparrot_clk, .rst_n_i, .rom_addr_o(rom_addr), .rom_data_i(rom_data),
    .load_base_o(load_base), .load_count_o(load_count), .load_seed_o(load_seed),
    .config_done_o(config_done)
  );

  // Both requesters stay quiet until the trace has finished
  io_loader u_io_loader (
    .hammerparrot_clk, .rst_n_i, .start_i(config_done), .load_base_i(load_base),
    .load_count_i(load_count), .load_seed_i(load_seed), .link(link_load),
    .loader_done_o
  );

  axil_host_bridge u_axil_host_bridge (
    .hammerparrot_clk, .rst_n_i, .enable_i(config_done),
    .awaddr_i, .awvalid_i, .awready_o, .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i, .araddr_i, .arvalid_i, .arready_o,
    .rdata_o, .rresp_o, .rvalid_o, .rready_i, .link(link_host)
  );

  link_arbiter u_link_arbiter (
    .hammerparrot_clk, .rst_n_i, .host(link_host), .load(link_load), .mem(link_mem)
  );

  mem_endpoint #(.MEM_WORDS(MEM_WORDS)) u_mem_endpoint (
    .hammerparrot_clk, .rst_n_i, .link(link_mem)
  );

  assign config_done_o = config_done;

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial clk_o = 1'b0;
  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// ==== hammerparrot_properties.sv ====
`timescale 1ns/10ps

module hammerparrot_properties (
  input logic        hammerparrot_clk,
  input logic        rst_n_i,
  input logic        host_valid_i,
  input logic        host_ready_i,
  input logic        host_rsp_i,
  input logic [11:0] host_addr_i,
  input logic [31:0] host_wdata_i,
  input logic        load_valid_i,
  input logic        load_ready_i,
  input logic        load_rsp_i,
  input logic [11:0] load_addr_i,
  input logic [31:0] load_wdata_i,
  input logic        mem_valid_i,
  input logic        mem_ready_i,
  input logic        mem_rsp_i
);

  // A waiting requester keeps its request up and unchanged until the transfer
  host_hold_a: assert property (@(posedge hammerparrot_clk) disable iff (!rst_n_i)
    host_valid_i && !host_ready_i |=>
      host_valid_i && $stable(host_addr_i) && $stable(host_wdata_i))
    else $error("host request changed or withdrawn before its transfer");

  load_hold_a: assert property (@(posedge hammerparrot_clk) disable iff (!rst_n_i)
    load_valid_i && !load_ready_i |=>
      load_valid_i && $stable(load_addr_i) && $stable(load_wdata_i))
    else $error("loader request changed or withdrawn before its transfer");

  //////////////////////////////////////////////////
  // Exactly one response per transfer

  rsp_follows_a: assert property (@(posedge hammerparrot_clk) disable iff (!rst_n_i)
    mem_valid_i && mem_ready_i |=> mem_rsp_i)
    else $error("no response in the cycle after a transfer");

  rsp_has_req_a: assert property (@(posedge hammerparrot_clk) disable iff (!rst_n_i)
    mem_rsp_i |-> $past(mem_valid_i && mem_ready_i))
    else $error("response without a preceding transfer");

  // The response goes back to the side whose request went through
  rsp_owner_a: assert property (@(posedge hammerparrot_clk) disable iff (!rst_n_i)
    mem_rsp_i |-> (host_rsp_i != load_rsp_i) &&
      (host_rsp_i ? $past(host_valid_i && host_ready_i)
                  : $past(load_valid_i && load_ready_i)))
    else $error("response steered to a requester without a transfer");

  // No second grant while a transaction is in flight
  one_grant_a: assert property (@(posedge hammerparrot_clk) disable iff (!rst_n_i)
    (host_valid_i && host_ready_i) || (load_valid_i && load_ready_i) |=>
      !host_ready_i && !load_ready_i)
    else $error("host and loader granted together");

endmodule

bind link_arbiter hammerparrot_properties u_hammerparrot_properties (
  .hammerparrot_clk(hammerparrot_clk),
  .rst_n_i(rst_n_i),
  .host_valid_i(host.req_valid),
  .host_ready_i(host.req_ready),
  .host_rsp_i(host.rsp_valid),
  .host_addr_i(host.req_addr),
  .host_wdata_i(host.req_wdata),
  .load_valid_i(load.req_valid),
  .load_ready_i(load.req_ready),
  .load_rsp_i(load.rsp_valid),
  .load_addr_i(load.req_addr),
  .load_wdata_i(load.req_wdata),
  .mem_valid_i(mem.req_valid),
  .mem_ready_i(mem.req_ready),
  .mem_rsp_i(mem.rsp_valid)
);

// ==== hammerparrot_tb.sv ====
`timescale 1ns/10ps

module hammerparrot_tb;

  localparam int MEM_WORDS = 256;
  localparam int ROM_WORDS = 16;
  localparam int IDX_W     = $clog2(MEM_WORDS);
  localparam int TIMEOUT   = 200;

  logic        hammerparrot_clk;
  logic        rst_n_i;
  logic [15:0] awaddr_i;
  logic        awvalid_i;
  logic        awready_o;
  logic [31:0] wdata_i;
  logic [3:0]  wstrb_i;
  logic        wvalid_i;
  logic        wready_o;
  logic [1:0]  bresp_o;
  logic        bvalid_o;
  logic        bready_i;
  logic [15:0] araddr_i;
  logic        arvalid_i;
  logic        arready_o;
  logic [31:0] rdata_o;
  logic [1:0]  rresp_o;
  logic        rvalid_o;
  logic        rready_i;
  logic        config_done_o;
  logic        loader_done_o;

  // Reference model state
  logic [31:0] ref_mem [MEM_WORDS];
  logic [31:0] ref_count;
  logic [19:0] trace_rom [ROM_WORDS];
  logic [11:0] load_base;
  logic [11:0] load_count;
  logic [31:0] load_seed;
  logic [31:0] rng_q;
  logic [11:0] host_addr [20];

  // Reads waiting for the compare process
  logic [11:0] rd_addr_q [$];
  logic [31:0] rd_got_q [$];
  logic [31:0] rd_exp_q [$];

  int error_count;
  int test_err_base;
  int test_count;
  int failed_tests;

  tb_clock_gen #(.PERIOD_NS(100)) u_tb_clock_gen (.clk_o(hammerparrot_clk));

  hammerparrot_top #(.MEM_WORDS(MEM_WORDS), .ROM_WORDS(ROM_WORDS)) u_hammerparrot_top (
    .hammerparrot_clk, .rst_n_i, .awaddr_i, .awvalid_i, .awready_o, .wdata_i, .wstrb_i,
    .wvalid_i, .wready_o, .bresp_o, .bvalid_o, .bready_i, .araddr_i, .arvalid_i,
    .arready_o, .rdata_o, .rresp_o, .rvalid_o, .rready_i, .config_done_o, .loader_done_o
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Bit 11 picks the control space, where register 0 is the write count
  function automatic logic [31:0] expected_word(input logic [11:0] addr);
    if (addr[11])
      return (addr[1:0] == 2'd0) ? ref_count : 32'h0;
    else
      return ref_mem[addr[IDX_W-1:0]];
  endfunction

  task automatic model_write(input logic [11:0] addr, input logic [31:0] data);
    if (!addr[11])
    begin
      ref_mem[addr[IDX_W-1:0]] = data;
      ref_count = ref_count + 1;
    end
  endtask

  task automatic model_preload();
    for (int i = 0; i < load_count; i++)
      model_write(load_base + 12'(i), load_seed + 32'(i));
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("** Error: %s got 0x%08h, expected 0x%08h", sig, got, exp);
    error_count++;
  endtask

  task automatic report_failure(input string what);
    $display("Failure: %s", what);
    error_count++;
  endtask

  task automatic next_drive_point();
    @(posedge hammerparrot_clk);
    #10;
  endtask

  task automatic parse_trace();
    logic [19:0] w;
    logic        stop;
    stop = 1'b0;
    for (int i = 0; i < ROM_WORDS; i++)
      trace_rom[i] = '0;
    $readmemh("trace.mem", trace_rom);
    for (int i = 0; i < ROM_WORDS && !stop; i++)
    begin
      w = trace_rom[i];
      case (w[19:16])
        hammerparrot_pkg::CMD_SET_BASE:  load_base  = w[11:0];
        hammerparrot_pkg::CMD_SET_COUNT: load_count = w[11:0];
        hammerparrot_pkg::CMD_SET_SEED:  load_seed  = {16'h0, w[15:0]};
        hammerparrot_pkg::CMD_END:       stop = 1'b1;
        default: ;
      endcase
    end
  endtask

  task automatic apply_reset();
    rst_n_i = 1'b0;
    repeat (2) @(posedge hammerparrot_clk);
    @(negedge hammerparrot_clk);
    assert ({awready_o, wready_o, bvalid_o, arready_o, rvalid_o, config_done_o,
             loader_done_o} == 7'h0)
      else report_failure("a valid, ready or done output is high during reset");
    next_drive_point();
    rst_n_i = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // AXI4-Lite master tasks

  task automatic axi_write(input logic [11:0] widx, input logic [31:0] data, input int hold);
    int n;
    awaddr_i  = {2'b00, widx, 2'b00};
    wdata_i   = data;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    n = 0;
    do
    begin
      @(negedge hammerparrot_clk);
      n++;
      assert (config_done_o || !awready_o)
        else report_failure("write accepted before configuration finished");
      assert (wready_o == awready_o) else report_mismatch("wready_o", wready_o, awready_o);
    end while (!awready_o && n < TIMEOUT);
    if (awready_o)
      model_write(widx, data);
    else
      report_failure("timeout waiting for awready_o");
    next_drive_point();
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    n = 0;
    while (!bvalid_o && n < TIMEOUT)
    begin
      @(negedge hammerparrot_clk);
      n++;
    end
    if (!bvalid_o)
    begin
      report_failure("timeout waiting for bvalid_o");
      next_drive_point();
    end
    else
    begin
      assert (bresp_o == 2'b00) else report_mismatch("bresp_o", bresp_o, 2'b00);
      repeat (hold)
      begin
        @(negedge hammerparrot_clk);
        assert (bvalid_o) else report_failure("bvalid_o dropped while bready_i was low");
      end
      next_drive_point();
      bready_i = 1'b1;
      next_drive_point();
      bready_i = 1'b0;
    end
  endtask

  task automatic axi_read(input logic [11:0] widx, input int hold);
    int          n;
    logic [31:0] data;
    araddr_i  = {2'b00, widx, 2'b00};
    arvalid_i = 1'b1;
    n = 0;
    do
    begin
      @(negedge hammerparrot_clk);
      n++;
    end while (!arready_o && n < TIMEOUT);
    if (!arready_o)
      report_failure("timeout waiting for arready_o");
    next_drive_point();
    arvalid_i = 1'b0;
    n = 0;
    while (!rvalid_o && n < TIMEOUT)
    begin
      @(negedge hammerparrot_clk);
      n++;
    end
    if (!rvalid_o)
    begin
      report_failure("timeout waiting for rvalid_o");
      next_drive_point();
    end
    else
    begin
      data = rdata_o;
      assert (rresp_o == 2'b00) else report_mismatch("rresp_o", rresp_o, 2'b00);
      rd_addr_q.push_back(widx);
      rd_got_q.push_back(data);
      rd_exp_q.push_back(expected_word(widx));
      repeat (hold)
      begin
        @(negedge hammerparrot_clk);
        assert (rvalid_o) else report_failure("rvalid_o dropped while rready_i was low");
        assert (rdata_o == data) else report_mismatch("rdata_o", rdata_o, data);
      end
      next_drive_point();
      rready_i = 1'b1;
      next_drive_point();
      rready_i = 1'b0;
    end
  endtask

  task automatic wait_loader_done();
    int n;
    n = 0;
    while (!loader_done_o && n < TIMEOUT)
    begin
      @(negedge hammerparrot_clk);
      n++;
    end
    if (!loader_done_o)
      report_failure("loader_done_o did not rise in time");
    next_drive_point();
  endtask

  // Compare process for every captured read
  always @(negedge hammerparrot_clk)
  begin
    logic [11:0] a;
    logic [31:0] got;
    logic [31:0] exp;
    while (rd_addr_q.size() > 0)
    begin
      a   = rd_addr_q.pop_front();
      got = rd_got_q.pop_front();
      exp = rd_exp_q.pop_front();
      assert (got == exp) else report_mismatch($sformatf("rdata_o[0x%03h]", a), got, exp);
    end
  end

  task automatic end_test(input string name);
    int n;
    int errs;
    n = 0;
    while (rd_addr_q.size() > 0 && n < 10)
    begin
      @(negedge hammerparrot_clk);
      n++;
    end
    if (rd_addr_q.size() > 0)
      report_failure("read results were never compared");
    next_drive_point();
    errs = error_count - test_err_base;
    test_count++;
    if (errs == 0)
      $display("Test %0d %s: ok", test_count, name);
    else
    begin
      failed_tests++;
      $display("Test %0d %s: %0d errors", test_count, name, errs);
    end
    test_err_base = error_count;
  endtask

  initial
  begin
    rst_n_i   = 1'b0;
    awaddr_i  = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = 4'hf;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    araddr_i  = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    ref_count = '0;
    load_base = '0;
    load_count = '0;
    load_seed = '0;
    rng_q     = 32'h321;
    error_count   = 0;
    test_err_base = 0;
    test_count    = 0;
    failed_tests  = 0;
    parse_trace();
    apply_reset();

    // A control space write is refused until the trace ends and then has no effect
    axi_write(12'h801, 32'hdead_beef, 0);
    assert (config_done_o) else report_failure("config_done_o did not rise");
    end_test("configuration");

    wait_loader_done();
    model_preload();
    for (int i = 0; i < load_count; i++)
      axi_read(load_base + 12'(i), 0);
    axi_read(12'h800, 0);
    end_test("preload");

    for (int i = 0; i < 20; i++)
    begin
      host_addr[i] = 12'h050 + 12'(i * 7);
      rng_q = xorshift32(rng_q);
      axi_write(host_addr[i], rng_q, 0);
    end
    for (int i = 0; i < 20; i++)
      axi_read(host_addr[(i * 7) % 20], 0);
    end_test("host write and read");

    rng_q = xorshift32(rng_q);
    axi_write(12'(MEM_WORDS + 5), rng_q, 0);
    axi_read(12'd5, 0);
    end_test("address wrap");

    // Host writes start right after reset and compete with the loader
    apply_reset();
    ref_count = '0;
    for (int i = 0; i < 6; i++)
    begin
      rng_q = xorshift32(rng_q);
      axi_write(12'h0e0 + 12'(i), rng_q, 0);
    end
    wait_loader_done();
    model_preload();
    for (int i = 0; i < load_count; i++)
      axi_read(load_base + 12'(i), 0);
    for (int i = 0; i < 6; i++)
      axi_read(12'h0e0 + 12'(i), 0);
    axi_read(12'h800, 0);
    end_test("contention and count");

    rng_q = xorshift32(rng_q);
    axi_write(12'h0f0, rng_q, 6);
    axi_read(12'h0f0, 6);
    end_test("back-pressure");

    $display("Summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests,
             error_count);
    if (error_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== trace.mem ====
// Trace ROM image, one 20-bit word per line: command nibble, then 16-bit payload
// Commands: 1 loader base, 2 word count, 3 pattern seed, f end of trace
10040
20008
31000
f0000

// ==== hammerparrot_mini.f ====
hammerparrot_pkg.sv
hp_link_if.sv
tag_trace_replay.sv
axil_host_bridge.sv
io_loader.sv
link_arbiter.sv
mem_endpoint.sv
hammerparrot_top.sv
tb_clock_gen.sv
hammerparrot_properties.sv
hammerparrot_tb.sv

// ==== Bender.yml ====
package:
  name: hammerparrot_mini

sources:
  - hammerparrot_pkg.sv
  - hp_link_if.sv
  - tag_trace_replay.sv
  - axil_host_bridge.sv
  - io_loader.sv
  - link_arbiter.sv
  - mem_endpoint.sv
  - hammerparrot_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - hammerparrot_properties.sv
      - hammerparrot_tb.sv
